/* Makefile */
# Verilator simulation of the operand RAM multiplier

VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = mult_ram_tb
FILELIST  = mult_ram.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir

/* mult_ram.f */
source/mult_ram_pkg.sv
source/mult_ram_if.sv
source/operand_ram.sv
source/operand_fetch.sv
source/shift_add_mult.sv
source/result_writeback.sv
source/seven_seg_display.sv
source/mult_ram_top.sv
verif/mult_ram_sva.sv
verif/mult_ram_tb.sv

/* source/mult_ram_if.sv */
// ===========================================================
// job and result interfaces
// single cycle valid strobes, no back-pressure
// ===========================================================
`timescale 1ns/1ps
`default_nettype none

// fetched job, operand_fetch -> shift_add_mult
interface job_if
        import mult_ram_pkg::*;
();
        logic  valid;   // one cycle per job
        addr_t addr;    // word the job came from
        nib_t  opa;
        nib_t  opb;

        modport src (output valid, output addr, output opa, output opb);
        modport dst (input valid, input addr, input opa, input opb);
endinterface

// finished job, carries the product along with its operands
interface result_if
        import mult_ram_pkg::*;
();
        logic  valid;
        addr_t addr;    // writeback target
        nib_t  opa;     // kept for the display
        nib_t  opb;
        prod_t prod;

        modport src (
                output valid, output addr, output opa, output opb, output prod
        );
        modport dst (
                input valid, input addr, input opa, input opb, input prod
        );
endinterface

`default_nettype wire

/* source/mult_ram_pkg.sv */
// ===========================================================
// mult_ram package
// widths, word field positions and depths shared by the
// operand RAM multiplier path
// ===========================================================
`default_nettype none

package mult_ram_pkg;

        // ===========================================================
        // types
        // ===========================================================
        typedef logic [3:0]  addr_t;    // RAM word address
        typedef logic [31:0] word_t;    // RAM data word
        typedef logic [3:0]  nib_t;     // operand or digit value
        typedef logic [7:0]  prod_t;    // A times B
        typedef logic [6:0]  seg_t;     // active low, bit0 = seg a, bit6 = seg g
        typedef logic [3:0]  cnt_t;     // completed results, wraps at 16

        // ===========================================================
        // sizes and word layout
        // ===========================================================
        localparam int RAM_DEPTH   = 16;
        localparam int MULT_STAGES = 4;  // one per operand B bit

        // word fields
        localparam int OPA_LSB  = 0;    // operand A in 3:0
        localparam int OPB_LSB  = 4;    // operand B in 7:4
        localparam int PROD_LSB = 8;    // product lands in byte 1

        // job strobe to result strobe
        // fetch 1 + mult 4 + writeback reg 1
        localparam int JOB_LATENCY = 6;

endpackage

`default_nettype wire

/* source/mult_ram_top.sv */
// ===========================================================
// operand RAM multiplier top
// RAM, fetch, pipelined multiplier, writeback and display
// ===========================================================
`timescale 1ns/1ps
`default_nettype none

module mult_ram_top
        import mult_ram_pkg::*;
(
        input  logic  fpga_clk_50,
        input  logic  hps_fpga_reset_n,
        // host RAM port
        input  logic  host_wr,
        input  logic  host_rd,
        input  addr_t host_addr,
        input  word_t host_wdata,
        output word_t host_rdata,
        // jobs
        input  logic  job_start,
        input  addr_t job_addr,
        output logic  result_valid,
        output addr_t result_addr,
        // display
        output seg_t  hex0,
        output seg_t  hex1,
        output seg_t  hex2,
        output seg_t  hex3,
        output seg_t  hex4,
        output seg_t  hex5
);

        // ===========================================================
        // internal connections
        // ===========================================================
        addr_t fetch_addr;
        word_t fetch_data;
        logic  wb_wr;
        addr_t wb_addr;
        prod_t wb_prod;

        job_if    job ();
        result_if mult_out ();
        result_if wb_out ();

        // ===========================================================
        // datapath
        // ===========================================================
        operand_ram u_ram (
                .fpga_clk_50      (fpga_clk_50),
                .hps_fpga_reset_n (hps_fpga_reset_n),
                .host_wr          (host_wr),
                .host_rd          (host_rd),
                .host_addr        (host_addr),
                .host_wdata       (host_wdata),
                .host_rdata       (host_rdata),
                .fetch_addr       (fetch_addr),
                .fetch_data       (fetch_data),
                .wb_wr            (wb_wr),
                .wb_addr          (wb_addr),
                .wb_prod          (wb_prod)
        );

        operand_fetch u_fetch (
                .fpga_clk_50      (fpga_clk_50),
                .hps_fpga_reset_n (hps_fpga_reset_n),
                .job_start        (job_start),
                .job_addr         (job_addr),
                .fetch_addr       (fetch_addr),
                .fetch_data       (fetch_data),
                .job              (job.src)
        );

        shift_add_mult u_mult (
                .fpga_clk_50      (fpga_clk_50),
                .hps_fpga_reset_n (hps_fpga_reset_n),
                .job              (job.dst),
                .res              (mult_out.src)
        );

        result_writeback u_wb (
                .fpga_clk_50      (fpga_clk_50),
                .hps_fpga_reset_n (hps_fpga_reset_n),
                .res_in           (mult_out.dst),
                .wb_wr            (wb_wr),
                .wb_addr          (wb_addr),
                .wb_prod          (wb_prod),
                .res_out          (wb_out.src)
        );

        seven_seg_display u_disp (
                .fpga_clk_50      (fpga_clk_50),
                .hps_fpga_reset_n (hps_fpga_reset_n),
                .res              (wb_out.dst),
                .hex0             (hex0),
                .hex1             (hex1),
                .hex2             (hex2),
                .hex3             (hex3),
                .hex4             (hex4),
                .hex5             (hex5)
        );

        // result strobe, JOB_LATENCY after job_start
        assign result_valid = wb_out.valid;
        assign result_addr  = wb_out.addr;

endmodule

`default_nettype wire

/* source/operand_fetch.sv */
// ===========================================================
// operand fetch
// reads the addressed word on job_start and splits it
// into operand A and operand B
// ===========================================================
`timescale 1ns/1ps
`default_nettype none

module operand_fetch
        import mult_ram_pkg::*;
(
        input  logic  fpga_clk_50,
        input  logic  hps_fpga_reset_n,
        input  logic  job_start,
        input  addr_t job_addr,
        output addr_t fetch_addr,
        input  word_t fetch_data,
        job_if.src    job
);

        assign fetch_addr = job_addr;   // RAM read is combinational

        // strobe, one cycle after job_start
        always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
        begin
                if (!hps_fpga_reset_n)
                        job.valid <= 1'b0;
                else
                        job.valid <= job_start;
        end

        // payload only moves with a job
        always_ff @(posedge fpga_clk_50)
        begin
                if (job_start)
                begin
                        job.addr <= job_addr;
                        job.opa  <= fetch_data[OPA_LSB +: $bits(nib_t)];
                        job.opb  <= fetch_data[OPB_LSB +: $bits(nib_t)];
                end
        end

endmodule

`default_nettype wire

/* source/operand_ram.sv */
// ===========================================================
// operand RAM, 16 x 32
// host read/write port, combinational fetch port and a
// byte 1 writeback port for the product
// ===========================================================
`timescale 1ns/1ps
`default_nettype none

module operand_ram
        import mult_ram_pkg::*;
(
        input  logic  fpga_clk_50,
        input  logic  hps_fpga_reset_n,
        // host side
        input  logic  host_wr,
        input  logic  host_rd,
        input  addr_t host_addr,
        input  word_t host_wdata,
        output word_t host_rdata,
        // job fetch
        input  addr_t fetch_addr,
        output word_t fetch_data,
        // product writeback
        input  logic  wb_wr,
        input  addr_t wb_addr,
        input  prod_t wb_prod
);

        word_t mem [RAM_DEPTH];

        // fetch sees the array directly, same cycle as job_start
        assign fetch_data = mem[fetch_addr];

        always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
        begin
                if (!hps_fpga_reset_n)
                begin
                        for (int i = 0; i < RAM_DEPTH; i++)
                                mem[i] <= '0;
                        host_rdata <= '0;
                end
                else
                begin
                        if (host_wr)
                                mem[host_addr] <= host_wdata;   // whole word
                        // later assignment, so writeback keeps byte 1 on a collision
                        if (wb_wr)
                                mem[wb_addr][PROD_LSB +: $bits(prod_t)] <= wb_prod;
                        if (host_rd)
                                host_rdata <= mem[host_addr];   // held until next read
                end
        end

endmodule

`default_nettype wire

/* source/result_writeback.sv */
// ===========================================================
// result writeback
// puts the product into byte 1 of its word and registers
// the result as the top level strobe
// ===========================================================
`timescale 1ns/1ps
`default_nettype none

module result_writeback
        import mult_ram_pkg::*;
(
        input  logic   fpga_clk_50,
        input  logic   hps_fpga_reset_n,
        result_if.dst  res_in,
        output logic   wb_wr,
        output addr_t  wb_addr,
        output prod_t  wb_prod,
        result_if.src  res_out
);

        // byte write goes out in the same cycle as the product
        assign wb_wr   = res_in.valid;
        assign wb_addr = res_in.addr;
        assign wb_prod = res_in.prod;

        always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
        begin
                if (!hps_fpga_reset_n)
                        res_out.valid <= 1'b0;
                else
                        res_out.valid <= res_in.valid;  // lines up with the RAM update
        end

        always_ff @(posedge fpga_clk_50)
        begin
                if (res_in.valid)
                begin
                        res_out.addr <= res_in.addr;
                        res_out.opa  <= res_in.opa;
                        res_out.opb  <= res_in.opb;
                        res_out.prod <= res_in.prod;
                end
        end

endmodule

`default_nettype wire

/* source/seven_seg_display.sv */
// ===========================================================
// seven segment display of the last result
// A, B, address, result count, product low, product high
// ===========================================================
`timescale 1ns/1ps
`default_nettype none

module seven_seg_display
        import mult_ram_pkg::*;
(
        input  logic  fpga_clk_50,
        input  logic  hps_fpga_reset_n,
        result_if.dst res,
        output seg_t  hex0,
        output seg_t  hex1,
        output seg_t  hex2,
        output seg_t  hex3,
        output seg_t  hex4,
        output seg_t  hex5
);

        cnt_t cnt;      // results seen, mod 16

        // active low glyphs, gfedcba
        function automatic seg_t seg_enc(input nib_t v);
                case (v)
                        4'h0: seg_enc = 7'b100_0000;
                        4'h1: seg_enc = 7'b111_1001;
                        4'h2: seg_enc = 7'b010_0100;
                        4'h3: seg_enc = 7'b011_0000;
                        4'h4: seg_enc = 7'b001_1001;
                        4'h5: seg_enc = 7'b001_0010;
                        4'h6: seg_enc = 7'b000_0010;
                        4'h7: seg_enc = 7'b111_1000;
                        4'h8: seg_enc = 7'b000_0000;
                        4'h9: seg_enc = 7'b001_0000;
                        4'ha: seg_enc = 7'b000_1000;    // A
                        4'hb: seg_enc = 7'b000_0011;    // b
                        4'hc: seg_enc = 7'b100_0110;    // C
                        4'hd: seg_enc = 7'b010_0001;    // d
                        4'he: seg_enc = 7'b000_0110;    // E
                        default: seg_enc = 7'b000_1110; // F
                endcase
        endfunction

        // digits latch straight from the result, visible the cycle after the strobe
        always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
        begin
                if (!hps_fpga_reset_n)
                begin
                        cnt  <= '0;
                        hex0 <= seg_enc(4'h0);
                        hex1 <= seg_enc(4'h0);
                        hex2 <= seg_enc(4'h0);
                        hex3 <= seg_enc(4'h0);
                        hex4 <= seg_enc(4'h0);
                        hex5 <= seg_enc(4'h0);
                end
                else if (res.valid)
                begin
                        cnt  <= cnt + cnt_t'(1);
                        hex0 <= seg_enc(res.opa);
                        hex1 <= seg_enc(res.opb);
                        hex2 <= seg_enc(res.addr);
                        hex3 <= seg_enc(cnt + cnt_t'(1));       // count including this one
                        hex4 <= seg_enc(res.prod[3:0]);
                        hex5 <= seg_enc(res.prod[7:4]);
                end
        end

endmodule

`default_nettype wire

/* source/shift_add_mult.sv */
// ===========================================================
// shift-add multiplier, 4 x 4 -> 8
// four registered stages, one B bit each, new job every cycle
// ===========================================================
`timescale 1ns/1ps
`default_nettype none

module shift_add_mult
        import mult_ram_pkg::*;
(
        input  logic     fpga_clk_50,
        input  logic     hps_fpga_reset_n,
        job_if.dst       job,
        result_if.src    res
);

        // per stage state, index k holds the result of B bit k
        logic [MULT_STAGES-1:0] st_valid;
        addr_t                  st_addr [MULT_STAGES];
        nib_t                   st_opa  [MULT_STAGES];
        nib_t                   st_opb  [MULT_STAGES];
        prod_t                  st_sum  [MULT_STAGES];

        // A << k when B bit k is set
        function automatic prod_t part_prod(input nib_t a, input nib_t b, input int k);
                part_prod = b[k] ? (prod_t'(a) << k) : '0;
        endfunction

        // ===========================================================
        // valid chain
        // ===========================================================
        always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
        begin
                if (!hps_fpga_reset_n)
                        st_valid <= '0;
                else
                        st_valid <= {st_valid[MULT_STAGES-2:0], job.valid};
        end

        // ===========================================================
        // payload, every stage moves each cycle
        // ===========================================================
        always_ff @(posedge fpga_clk_50)
        begin
                st_addr[0] <= job.addr;
                st_opa[0]  <= job.opa;
                st_opb[0]  <= job.opb;
                st_sum[0]  <= part_prod(job.opa, job.opb, 0);   // first term, no add
                for (int k = 1; k < MULT_STAGES; k++)
                begin
                        st_addr[k] <= st_addr[k-1];
                        st_opa[k]  <= st_opa[k-1];
                        st_opb[k]  <= st_opb[k-1];
                        st_sum[k]  <= st_sum[k-1] + part_prod(st_opa[k-1], st_opb[k-1], k);
                end
        end

        // last stage is the finished product
        assign res.valid = st_valid[MULT_STAGES-1];
        assign res.addr  = st_addr[MULT_STAGES-1];
        assign res.opa   = st_opa[MULT_STAGES-1];
        assign res.opb   = st_opb[MULT_STAGES-1];
        assign res.prod  = st_sum[MULT_STAGES-1];

endmodule

`default_nettype wire

/* verif/mult_ram_sva.sv */
// ===========================================================
// job to result timing checks on the multiplier top
// ===========================================================
`timescale 1ns/1ps
`default_nettype none

module mult_ram_sva
        import mult_ram_pkg::*;
(
        input logic  fpga_clk_50,
        input logic  hps_fpga_reset_n,
        input logic  job_start,
        input addr_t job_addr,
        input logic  result_valid,
        input addr_t result_addr
);

        // strobe must be a clean 0 or 1 once out of reset
        a_valid_known: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
                !$isunknown(result_valid))
                else $error("result_valid is unknown");

        // every job comes out exactly JOB_LATENCY later
        a_job_to_result: assert property (@(posedge fpga_clk_50)
                disable iff (!hps_fpga_reset_n)
                job_start |-> ##JOB_LATENCY result_valid)
                else $error("no result strobe JOB_LATENCY cycles after job_start");

        // and no strobe without a job behind it
        a_result_from_job: assert property (@(posedge fpga_clk_50)
                disable iff (!hps_fpga_reset_n)
                result_valid |-> $past(job_start, JOB_LATENCY))
                else $error("result strobe without a matching job_start");

        a_result_addr: assert property (@(posedge fpga_clk_50)
                disable iff (!hps_fpga_reset_n)
                result_valid |-> result_addr == $past(job_addr, JOB_LATENCY))
                else $error("result_addr differs from the job address");

endmodule

bind mult_ram_top mult_ram_sva u_sva (
        .fpga_clk_50      (fpga_clk_50),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .job_start        (job_start),
        .job_addr         (job_addr),
        .result_valid     (result_valid),
        .result_addr      (result_addr)
);

`default_nettype wire

/* verif/mult_ram_tb.sv */
// ===========================================================
// testbench for the operand RAM multiplier
// host loads, single and back-to-back jobs, all products,
// display digits and a host/writeback collision
// ===========================================================
`timescale 1ns/1ps
`default_nettype none

module mult_ram_tb
        import mult_ram_pkg::*;
();

        // about 80 cycles per exhaustive batch
        localparam int EST_CYCLES     = RAM_DEPTH * 80 + 320;
        localparam int TIMEOUT_CYCLES = 3 * EST_CYCLES + 200;   // 5000
        localparam int N_SINGLE       = 8;

        // active low hex glyphs in gfedcba order
        localparam seg_t GLYPHS [16] = '{
                7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
        };

        typedef struct packed {
                int    cyc;     // cycle the job strobe was seen
                addr_t addr;
                nib_t  opa;
                nib_t  opb;
        } job_rec_t;

        // ===========================================================
        // DUT signals
        // ===========================================================
        logic  fpga_clk_50;
        logic  hps_fpga_reset_n;
        logic  host_wr;
        logic  host_rd;
        addr_t host_addr;
        word_t host_wdata;
        word_t host_rdata;
        logic  job_start;
        addr_t job_addr;
        logic  result_valid;
        addr_t result_addr;
        seg_t  hex0;
        seg_t  hex1;
        seg_t  hex2;
        seg_t  hex3;
        seg_t  hex4;
        seg_t  hex5;

        // expected state kept by the compare process
        word_t    shadow [RAM_DEPTH] = '{default: '0};
        job_rec_t pending [$];                  // jobs in flight in issue order
        cnt_t     res_count = '0;
        logic     reset_checked = 1'b0;
        logic     rd_due = 1'b0;
        word_t    rd_exp = '0;
        logic     disp_due = 1'b0;
        seg_t     disp_exp [6];
        int       errors = 0;
        int       checks = 0;

        word_t    lcg_state = 32'h7113_733f;
        int       cyc = 0;

        mult_ram_top u_dut (
                .fpga_clk_50      (fpga_clk_50),
                .hps_fpga_reset_n (hps_fpga_reset_n),
                .host_wr          (host_wr),
                .host_rd          (host_rd),
                .host_addr        (host_addr),
                .host_wdata       (host_wdata),
                .host_rdata       (host_rdata),
                .job_start        (job_start),
                .job_addr         (job_addr),
                .result_valid     (result_valid),
                .result_addr      (result_addr),
                .hex0             (hex0),
                .hex1             (hex1),
                .hex2             (hex2),
                .hex3             (hex3),
                .hex4             (hex4),
                .hex5             (hex5)
        );

        initial
        begin
                fpga_clk_50 = 1'b0;
                forever #2 fpga_clk_50 = ~fpga_clk_50;  // 4 ns
        end

        always @(posedge fpga_clk_50)
                cyc <= cyc + 1;

        initial
        begin
                wait (cyc >= TIMEOUT_CYCLES);
                $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
                $display("RESULT: FAIL");
                $finish;
        end

        // ===========================================================
        // reference model and helpers
        // ===========================================================
        function automatic word_t next_rand();
                lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
                return lcg_state;
        endfunction

        // A times B as an 8 bit product
        function automatic prod_t ref_prod(input nib_t a, input nib_t b);
                return prod_t'(a) * prod_t'(b);
        endfunction

        task automatic check_value(input string what, input word_t got, input word_t exp);
                checks++;
                assert (got == exp)
                else
                begin
                        errors++;
                        $display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
                end
        endtask

        // ===========================================================
        // compare process sampling mid cycle
        // ===========================================================
        always @(negedge fpga_clk_50)
        begin : compare
                job_rec_t r;
                prod_t    p;
                seg_t     hex_now [6];
                hex_now = '{hex0, hex1, hex2, hex3, hex4, hex5};
                if (hps_fpga_reset_n)
                begin
                        if (!reset_checked)
                        begin
                                reset_checked = 1'b1;
                                check_value("result_valid after reset", word_t'(result_valid), '0);
                                check_value("host_rdata after reset", host_rdata, '0);
                                for (int i = 0; i < 6; i++)
                                        disp_exp[i] = GLYPHS[0];
                                disp_due = 1'b1;
                        end
                        if (disp_due)   // digits of the previous result
                        begin
                                for (int i = 0; i < 6; i++)
                                        check_value($sformatf("hex%0d", i), word_t'(hex_now[i]),
                                                word_t'(disp_exp[i]));
                                disp_due = 1'b0;
                        end
                        if (rd_due)
                        begin
                                check_value("host_rdata", host_rdata, rd_exp);
                                rd_due = 1'b0;
                        end
                        if (result_valid)       // byte 1 landed on the edge just gone
                        begin
                                assert (pending.size() != 0)
                                else
                                begin
                                        errors++;
                                        $display("result strobe at %0t ns with no job in flight",
                                                $time);
                                end
                                if (pending.size() != 0)
                                begin
                                        r = pending.pop_front();
                                        check_value("result_addr", word_t'(result_addr),
                                                word_t'(r.addr));
                                        check_value("job latency", word_t'(cyc - r.cyc),
                                                word_t'(JOB_LATENCY));
                                        p = ref_prod(r.opa, r.opb);
                                        shadow[r.addr][PROD_LSB +: 8] = p;  // writeback owns byte 1
                                        res_count   = res_count + cnt_t'(1);
                                        disp_exp[0] = GLYPHS[r.opa];
                                        disp_exp[1] = GLYPHS[r.opb];
                                        disp_exp[2] = GLYPHS[r.addr];
                                        disp_exp[3] = GLYPHS[res_count];
                                        disp_exp[4] = GLYPHS[p[3:0]];
                                        disp_exp[5] = GLYPHS[p[7:4]];
                                        disp_due    = 1'b1;
                                end
                        end
                        if (host_rd)    // read sees the word before this edge's writes
                        begin
                                rd_due = 1'b1;
                                rd_exp = shadow[host_addr];
                        end
                        if (job_start)  // fetch also sees the word before the write
                        begin
                                r.cyc  = cyc;
                                r.addr = job_addr;
                                r.opa  = shadow[job_addr][OPA_LSB +: 4];
                                r.opb  = shadow[job_addr][OPB_LSB +: 4];
                                pending.push_back(r);
                        end
                        if (host_wr)
                                shadow[host_addr] = host_wdata;
                end
        end

        // ===========================================================
        // stimulus tasks of one rising edge each
        // ===========================================================
        task automatic drive_write(input addr_t a, input word_t w);
                @(posedge fpga_clk_50);
                host_wr    <= 1'b1;
                host_rd    <= 1'b0;
                job_start  <= 1'b0;
                host_addr  <= a;
                host_wdata <= w;
        endtask

        task automatic drive_read(input addr_t a);
                @(posedge fpga_clk_50);
                host_wr   <= 1'b0;
                host_rd   <= 1'b1;
                job_start <= 1'b0;
                host_addr <= a;
        endtask

        task automatic drive_job(input addr_t a);
                @(posedge fpga_clk_50);
                host_wr   <= 1'b0;
                host_rd   <= 1'b0;
                job_start <= 1'b1;
                job_addr  <= a;
        endtask

        task automatic drive_idle(input int n);
                repeat (n)
                begin
                        @(posedge fpga_clk_50);
                        host_wr   <= 1'b0;
                        host_rd   <= 1'b0;
                        job_start <= 1'b0;
                end
        endtask

        task automatic wait_drain();
                while (pending.size() != 0)
                        drive_idle(1);
                drive_idle(2);  // let display and read checks land
        endtask

        task automatic read_all();
                for (int i = 0; i < RAM_DEPTH; i++)
                        drive_read(addr_t'(i));
                drive_idle(2);
        endtask

        // ===========================================================
        // test sequence
        // ===========================================================
        initial
        begin
                word_t w;
                addr_t a;
                hps_fpga_reset_n = 1'b0;
                host_wr          = 1'b0;
                host_rd          = 1'b0;
                host_addr        = '0;
                host_wdata       = '0;
                job_start        = 1'b0;
                job_addr         = '0;
                repeat (5) @(posedge fpga_clk_50);
                hps_fpga_reset_n <= 1'b1;
                drive_idle(2);

                // single jobs on random words
                for (int n = 0; n < N_SINGLE; n++)
                begin
                        w = next_rand();
                        a = addr_t'(next_rand() >> 28);
                        drive_write(a, w);
                        drive_job(a);
                        wait_drain();
                        drive_read(a);
                        drive_idle(2);
                end

                // back-to-back over every address
                for (int i = 0; i < RAM_DEPTH; i++)
                        drive_write(addr_t'(i), next_rand());
                for (int i = 0; i < RAM_DEPTH; i++)
                        drive_job(addr_t'(i));
                wait_drain();
                read_all();

                // all 256 operand pairs with B fixed per batch
                for (int b = 0; b < 16; b++)
                begin
                        for (int i = 0; i < RAM_DEPTH; i++)
                        begin
                                w = next_rand();
                                drive_write(addr_t'(i), {w[31:8], nib_t'(b), nib_t'(i)});
                        end
                        for (int i = 0; i < RAM_DEPTH; i++)
                                drive_job(addr_t'(i));
                        wait_drain();
                        read_all();
                end

                // host write on the writeback edge
                a = addr_t'(9);
                drive_write(a, 32'h1234_5687);  // A is 7 and B is 8
                drive_job(a);
                drive_idle(4);
                drive_write(a, 32'hcafe_f00d);  // sampled with the byte 1 write
                wait_drain();
                drive_read(a);
                drive_idle(4);

                $display("checks: %0d, errors: %0d", checks, errors);
                if (errors == 0 && checks > 0)
                        $display("RESULT: PASS");
                else
                        $display("RESULT: FAIL");
                $finish;
        end

endmodule

`default_nettype wire
